// File: source/ex_pkg.sv
package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Integer datapath width
  localparam int unsigned WORD_W     = 32;
  // Register file holds 32 entries
  localparam int unsigned REG_ADDR_W = 5;
  // Shift amount covers one word
  localparam int unsigned SHAMT_W    = $clog2(WORD_W);
  // Operand B is split in two slices for the high products
  localparam int unsigned SLICE_W    = WORD_W / 2;

  // Operands, results, CSR and load data
  typedef logic [WORD_W-1:0]     word_t;
  // Register file address
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////
  // Opcodes
  ////////////////////

  // ALU operations with the compares last
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // MUL, MULH, MULHSU, MULHU
  typedef enum logic [1:0] {
    MUL_LO,
    MUL_HSS,
    MUL_HSU,
    MUL_HUU
  } mult_op_e;

  // High-half product sequencer
  typedef enum logic [1:0] {
    MS_IDLE,
    MS_STEP,
    MS_DONE
  } mult_state_e;

endpackage

// File: source/ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            comparison_result_o
);

  import ex_pkg::*;

  logic              sub_en;
  logic              signed_cmp;
  logic [WORD_W:0]   adder_a;
  logic [WORD_W:0]   adder_b;
  logic [WORD_W:0]   adder_sum;
  logic              is_less;
  logic              is_equal;
  logic              shift_left;
  logic              shift_arith;
  logic [SHAMT_W-1:0] shift_amt;
  word_t             shift_in;
  logic [WORD_W:0]   shift_ext;
  word_t             shift_right;
  word_t             shift_result;
  logic              cmp_result;

  // Mirror a word for left shifts through the right shifter
  function automatic word_t bit_reverse(input word_t value);
    word_t reversed;
    for (int i = 0; i < WORD_W; i++) begin
      reversed[i] = value[WORD_W-1-i];
    end
    return reversed;
  endfunction

  ////////////////////
  // Adder
  ////////////////////

  // Only ADD adds; everything else using the adder subtracts
  assign sub_en     = (operator_i != ALU_ADD);
  assign signed_cmp = (operator_i == ALU_SLT) || (operator_i == ALU_LT) ||
                      (operator_i == ALU_GE);

  // One extra bit so the difference sign is the less-than flag
  assign adder_a = {signed_cmp & operand_a_i[WORD_W-1], operand_a_i};
  assign adder_b = {signed_cmp & operand_b_i[WORD_W-1], operand_b_i};

  // Two's complement subtract via inverted B and carry in
  assign adder_sum = adder_a + (sub_en ? ~adder_b : adder_b) +
                     {{WORD_W{1'b0}}, sub_en};

  assign is_less  = adder_sum[WORD_W];
  assign is_equal = (adder_sum[WORD_W-1:0] == '0);

  ////////////////////
  // Shifter
  ////////////////////

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);
  assign shift_amt   = operand_b_i[SHAMT_W-1:0];

  // Left shift is a right shift of the mirrored operand
  assign shift_in = shift_left ? bit_reverse(operand_a_i) : operand_a_i;

  // Fill bit is the sign only for SRA
  assign shift_ext   = $signed({shift_arith & shift_in[WORD_W-1], shift_in}) >>> shift_amt;
  assign shift_right = shift_ext[WORD_W-1:0];

  assign shift_result = shift_left ? bit_reverse(shift_right) : shift_right;

  ////////////////////
  // Comparator
  ////////////////////

  always_comb begin
    case (operator_i)
      ALU_EQ:                    cmp_result = is_equal;
      ALU_NE:                    cmp_result = ~is_equal;
      // Signedness is already folded into the adder extension bit
      ALU_SLT, ALU_LT, ALU_SLTU, ALU_LTU: cmp_result = is_less;
      // GE and GEU are the inverse of the less-than flag
      ALU_GE, ALU_GEU:           cmp_result = ~is_less;
      default:                   cmp_result = 1'b0;
    endcase
  end

  // Branch decision
  assign comparison_result_o = cmp_result;

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = adder_sum[WORD_W-1:0];
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      // Compares give a 0 or 1 word
      default:                   result_o = {{(WORD_W-1){1'b0}}, cmp_result};
    endcase
  end

endmodule

// File: source/ex_mult.sv
`timescale 1ns/100ps

module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::word_t    op_a_i,
  input  ex_pkg::word_t    op_b_i,
  input  logic             ex_ready_i,
  output ex_pkg::word_t    result_o,
  output logic             multicycle_o,
  output logic             ready_o
);

  import ex_pkg::*;

  mult_state_e                state_q;
  mult_state_e                state_d;
  logic                       high_op;
  logic                       sign_a;
  logic                       sign_b;
  logic [WORD_W:0]            a_ext;
  logic [WORD_W:0]            b_ext;
  logic signed [2*WORD_W-1:0] pp_lo;
  logic signed [2*WORD_W-1:0] pp_hi;
  logic signed [2*WORD_W-1:0] acc_q;
  logic signed [2*WORD_W-1:0] acc_d;
  word_t                      lo_result;
  logic                       multicycle_q;

  ////////////////////
  // Operands
  ////////////////////

  assign high_op = (operator_i != MUL_LO);

  // MULH is signed by signed, MULHSU signed by unsigned
  assign sign_a = (operator_i == MUL_HSS) || (operator_i == MUL_HSU);
  assign sign_b = (operator_i == MUL_HSS);

  assign a_ext = {sign_a & op_a_i[WORD_W-1], op_a_i};
  assign b_ext = {sign_b & op_b_i[WORD_W-1], op_b_i};

  // Single-cycle MUL keeps only the low word
  assign lo_result = op_a_i * op_b_i;

  // Lower slice of B is always unsigned
  assign pp_lo = $signed(a_ext) * $signed({1'b0, op_b_i[SLICE_W-1:0]});
  // Upper slice carries the sign of B
  assign pp_hi = $signed(a_ext) * $signed(b_ext[WORD_W:SLICE_W]);

  ////////////////////
  // Sequencer
  ////////////////////

  always_comb begin
    state_d = state_q;
    acc_d   = acc_q;
    case (state_q)
      MS_IDLE: begin
        // First step stores the lower partial product
        if (enable_i && high_op) begin
          acc_d   = pp_lo;
          state_d = MS_STEP;
        end
      end
      MS_STEP: begin
        // Add the upper partial product at its slice offset
        acc_d   = acc_q + (pp_hi <<< SLICE_W);
        state_d = MS_DONE;
      end
      MS_DONE: begin
        // Hold the product until EX hands it on
        if (ex_ready_i) begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= MS_IDLE;
      multicycle_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // Flag a multicycle op from the first step until back in idle
      multicycle_q <= (state_d != MS_IDLE);
    end
  end

  // Product accumulator
  always_ff @(posedge clk) begin
    acc_q <= acc_d;
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign multicycle_o = multicycle_q;

  assign ready_o = ((state_q == MS_IDLE) && (!enable_i || !high_op)) ||
                   (state_q == MS_DONE);

  // High opcodes return the upper word of the accumulated product
  assign result_o = high_op ? acc_q[2*WORD_W-1:WORD_W] : lo_result;

endmodule

// File: source/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,

  // ALU from ID
  input  logic              alu_en_i,
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,

  // Multiplier from ID
  input  logic              mult_en_i,
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,

  // CSR read
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,

  // LSU
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,

  input  logic              branch_in_ex_i,

  // Destination registers from ID
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  input  logic              wb_ready_i,

  // Forwarding port to ID and register file
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,

  // Load write-back port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,

  // Branch to IF
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,

  // Stall control
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  word_t     alu_result;
  logic      alu_cmp_result;
  word_t     mult_result;
  logic      mult_ready;
  logic      units_ready;
  logic      regfile_we_lsu;
  reg_addr_t regfile_waddr_lsu;

  ////////////////////
  // Units
  ////////////////////

  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  // Multicycle results wait on the stage ready
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ////////////////////
  // Forwarding mux
  ////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Later enables win; CSR data has the highest priority
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result;
    end
    if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result;
    end
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end
  end

  // Branch target comes precomputed from ID
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu    <= 1'b0;
      regfile_waddr_lsu <= '0;
    end else if (ex_valid_o) begin
      regfile_we_lsu <= regfile_we_i;
      // Address only moves for a real write
      if (regfile_we_i) begin
        regfile_waddr_lsu <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new from EX, so flush the slot
      regfile_we_lsu <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = regfile_we_lsu;
  assign regfile_waddr_wb_o = regfile_waddr_lsu;
  // Load data arrives straight from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

  ////////////////////
  // Handshake
  ////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX and never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid goes forward only, independent of ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// File: verification/ex_stage_checker.sv
`timescale 1ns/100ps

module ex_stage_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                unit_en_i,
  input  logic                ex_ready_i,
  input  logic                ex_valid_i,
  input  logic                mult_multicycle_i,
  input  ex_pkg::mult_state_e mult_state_i,
  input  ex_pkg::reg_addr_t   fw_waddr_i,
  input  logic                we_wb_i
);

  import ex_pkg::*;

  // No valid while a high product is still being built
  valid_after_step: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_multicycle_i && (mult_state_i != MS_DONE)) |-> !ex_valid_i)
    else $error("ex_valid_o high before the multiplier reached MS_DONE");

  // A stalled instruction keeps its forwarding address
  stall_holds_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_ready_i && unit_en_i) |=> $stable(fw_waddr_i))
    else $error("forwarding address changed during a stall");

  // EX/WB slot stays empty in reset
  wb_idle_in_reset: assert property (@(posedge clk)
    !rst_n |-> !we_wb_i)
    else $error("regfile_we_wb_o high during reset");

endmodule

bind ex_stage ex_stage_checker u_checker (
  .clk               (clk),
  .rst_n             (rst_n),
  .unit_en_i         (alu_en_i | mult_en_i | csr_access_i | lsu_en_i),
  .ex_ready_i        (ex_ready_o),
  .ex_valid_i        (ex_valid_o),
  .mult_multicycle_i (mult_multicycle_o),
  .mult_state_i      (u_mult.state_q),
  .fw_waddr_i        (regfile_alu_waddr_fw_o),
  .we_wb_i           (regfile_we_wb_o)
);

// File: verification/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb;

  import ex_pkg::*;

  localparam int unsigned CLK_PERIOD    = 40;
  localparam int unsigned RESET_CYCLES  = 10;
  localparam int unsigned NUM_INSTR     = 400;
  // Budget per instruction with back-pressure
  localparam int unsigned INSTR_CYCLES  = 8;
  localparam int unsigned WATCHDOG_TIME = (NUM_INSTR * INSTR_CYCLES + RESET_CYCLES) * CLK_PERIOD;

  // Instruction kinds
  localparam int unsigned KIND_ALU      = 0;
  localparam int unsigned KIND_MULT     = 1;
  localparam int unsigned KIND_CSR      = 2;
  localparam int unsigned KIND_LSU      = 3;
  localparam int unsigned KIND_BRANCH   = 4;

  logic      clk;
  logic      rst_n;
  logic      alu_en_i;
  alu_op_e   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  word_t     alu_operand_c_i;
  logic      mult_en_i;
  mult_op_e  mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      branch_in_ex_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      wb_ready_i;
  logic      regfile_alu_we_fw_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  word_t     regfile_alu_wdata_fw_o;
  logic      regfile_we_wb_o;
  reg_addr_t regfile_waddr_wb_o;
  word_t     regfile_wdata_wb_o;
  word_t     jump_target_o;
  logic      branch_decision_o;
  logic      mult_multicycle_o;
  logic      ex_ready_o;
  logic      ex_valid_o;

  integer      seed;
  int unsigned check_count;
  int unsigned error_count;
  int unsigned checks_mark;
  int unsigned errors_mark;
  // EX/WB register model
  logic        wb_we_exp;
  reg_addr_t   wb_addr_exp;

  ex_stage u_ex_stage (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic compare_model(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $signed(a) >>> b[4:0];
      default: return {31'b0, compare_model(op, a, b)};
    endcase
  endfunction

  function automatic word_t mult_model(input mult_op_e op, input word_t a, input word_t b);
    logic [63:0] a_wide;
    logic [63:0] b_wide;
    logic [63:0] product;
    // Sign handling per opcode, then a plain 64-bit product
    a_wide  = (op == MUL_HSS || op == MUL_HSU) ? {{32{a[31]}}, a} : {32'b0, a};
    b_wide  = (op == MUL_HSS) ? {{32{b[31]}}, b} : {32'b0, b};
    product = a_wide * b_wide;
    return (op == MUL_LO) ? product[31:0] : product[63:32];
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("FAIL %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("FAIL %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("FAIL %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  // Write-back port against the EX/WB model
  task automatic check_write_back();
    check_bit("regfile_we_wb_o", wb_we_exp, regfile_we_wb_o);
    check_addr("regfile_waddr_wb_o", wb_addr_exp, regfile_waddr_wb_o);
    check_word("regfile_wdata_wb_o", lsu_rdata_i, regfile_wdata_wb_o);
  endtask

  task automatic report_test(input string name);
    $display("%s test done: %0d checks, %0d errors", name, check_count - checks_mark,
             error_count - errors_mark);
    checks_mark = check_count;
    errors_mark = error_count;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Each ready drops about one cycle in four
  task automatic draw_backpressure();
    wb_ready_i     <= ($random(seed) & 3) != 0;
    lsu_ready_ex_i <= ($random(seed) & 3) != 0;
  endtask

  task automatic drive_idle();
    alu_en_i            <= 1'b0;
    alu_operator_i      <= ALU_ADD;
    alu_operand_a_i     <= '0;
    alu_operand_b_i     <= '0;
    alu_operand_c_i     <= '0;
    mult_en_i           <= 1'b0;
    mult_operator_i     <= MUL_LO;
    mult_operand_a_i    <= '0;
    mult_operand_b_i    <= '0;
    csr_access_i        <= 1'b0;
    csr_rdata_i         <= '0;
    lsu_en_i            <= 1'b0;
    lsu_rdata_i         <= '0;
    lsu_ready_ex_i      <= 1'b1;
    branch_in_ex_i      <= 1'b0;
    regfile_alu_we_i    <= 1'b0;
    regfile_alu_waddr_i <= '0;
    regfile_we_i        <= 1'b0;
    regfile_waddr_i     <= '0;
    wb_ready_i          <= 1'b1;
  endtask

  // No enables, so every edge flushes the EX/WB slot
  task automatic idle_cycles(input int unsigned count);
    drive_idle();
    repeat (count) begin
      @(negedge clk);
      check_bit("ex_valid_o", 1'b0, ex_valid_o);
      check_bit("ex_ready_o", 1'b1, ex_ready_o);
      check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);
      check_write_back();
      wb_we_exp = 1'b0;
      @(posedge clk);
    end
  endtask

  // Present one random instruction and hold it until the stage takes it
  task automatic issue_instr();
    int unsigned kind;
    int unsigned cycle;
    logic        high_op;
    logic        units_ok;
    logic        exp_ready;
    logic        exp_valid;
    logic        accepted;
    word_t       op_a;
    word_t       exp_data;

    kind = $unsigned($random(seed)) % 5;
    op_a = $random(seed);
    alu_en_i        <= (kind == KIND_ALU);
    alu_operand_a_i <= op_a;
    // Equal operands now and then for EQ and GE
    alu_operand_b_i <= (($random(seed) & 7) == 0) ? op_a : word_t'($random(seed));
    alu_operand_c_i <= $random(seed);
    if (kind == KIND_BRANCH) begin
      alu_operator_i <= alu_op_e'(4'(int'(ALU_EQ) + $unsigned($random(seed)) % 6));
    end else begin
      alu_operator_i <= alu_op_e'(4'($random(seed)));
    end
    mult_en_i           <= (kind == KIND_MULT);
    mult_operator_i     <= mult_op_e'(2'($random(seed)));
    mult_operand_a_i    <= $random(seed);
    mult_operand_b_i    <= $random(seed);
    csr_access_i        <= (kind == KIND_CSR);
    csr_rdata_i         <= $random(seed);
    lsu_en_i            <= (kind == KIND_LSU);
    lsu_rdata_i         <= $random(seed);
    branch_in_ex_i      <= (kind == KIND_BRANCH);
    regfile_alu_we_i    <= (kind < KIND_LSU) && (($random(seed) & 1) != 0);
    regfile_alu_waddr_i <= 5'($random(seed));
    regfile_we_i        <= (kind == KIND_LSU) && (($random(seed) & 3) != 0);
    regfile_waddr_i     <= 5'($random(seed));
    draw_backpressure();

    cycle    = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      high_op   = (kind == KIND_MULT) && (mult_operator_i != MUL_LO);
      // High products are ready from their third cycle on
      units_ok  = !(high_op && cycle < 2) && lsu_ready_ex_i && wb_ready_i;
      exp_ready = units_ok || (kind == KIND_BRANCH);
      exp_valid = units_ok && (kind != KIND_BRANCH);
      case (kind)
        KIND_ALU:  exp_data = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
        KIND_MULT: exp_data = mult_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
        KIND_CSR:  exp_data = csr_rdata_i;
        default:   exp_data = '0;
      endcase
      check_bit("ex_ready_o", exp_ready, ex_ready_o);
      check_bit("ex_valid_o", exp_valid, ex_valid_o);
      check_bit("mult_multicycle_o", high_op && (cycle >= 1), mult_multicycle_o);
      check_bit("regfile_alu_we_fw_o", regfile_alu_we_i, regfile_alu_we_fw_o);
      check_addr("regfile_alu_waddr_fw_o", regfile_alu_waddr_i, regfile_alu_waddr_fw_o);
      check_write_back();
      if (exp_valid) begin
        check_word("regfile_alu_wdata_fw_o", exp_data, regfile_alu_wdata_fw_o);
      end
      if (kind == KIND_BRANCH) begin
        check_bit("branch_decision_o",
                  compare_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
                  branch_decision_o);
        check_word("jump_target_o", alu_operand_c_i, jump_target_o);
      end
      // EX/WB slot as it will look after this edge
      if (exp_valid) begin
        wb_we_exp = regfile_we_i;
        if (regfile_we_i) begin
          wb_addr_exp = regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        wb_we_exp = 1'b0;
      end
      accepted = exp_ready;
      @(posedge clk);
      cycle++;
      if (!accepted) begin
        draw_backpressure();
      end
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    seed        = 32'h2268;
    check_count = 0;
    error_count = 0;
    checks_mark = 0;
    errors_mark = 0;
    wb_we_exp   = 1'b0;
    wb_addr_exp = '0;
    rst_n       = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    idle_cycles(2);
    report_test("reset");

    repeat (NUM_INSTR) issue_instr();
    report_test("random instructions");

    // Last load drains out of the EX/WB slot
    idle_cycles(4);
    report_test("flush");

    $display("Totals: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Hang guard sized from the instruction budget
  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired: the stage stopped accepting instructions");
    $display("Test failed");
    $finish;
  end

endmodule

// File: vlog.f
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_stage.sv
verification/ex_stage_checker.sv
verification/ex_stage_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILE_LIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

SIM_BIN   = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
